// File: test/mem_subsys_tests.txt
# op port addr wdata strb exp_data exp_resp pair, all numbers hex, resp 0 okay 2 slverr
# pair 1 starts the next line in the same cycle on the other port
W ls 80000000 0123456789abcdef ff 0000000000000000 0 0
R ls 80000000 0000000000000000 00 0123456789abcdef 0 0
R if 80000000 0000000000000000 00 0123456789abcdef 0 0
W ls 800007f8 a5a5a5a5c3c3c3c3 ff 0000000000000000 0 0
R if 800007f8 0000000000000000 00 a5a5a5a5c3c3c3c3 0 0
# byte strobes merge into the stored word
W ls 80000010 0102030405060708 0f 0000000000000000 0 0
W ls 80000010 1122334455667788 f0 0000000000000000 0 0
R ls 80000010 0000000000000000 00 1122334405060708 0 0
W ls 80000018 0000000000000000 ff 0000000000000000 0 0
W ls 80000018 ffffffffffffffff 5a 0000000000000000 0 0
R if 80000018 0000000000000000 00 00ff00ffff00ff00 0 0
# outside the window, above and below
W ls 80000800 deadbeefdeadbeef ff 0000000000000000 2 0
R if 80000000 0000000000000000 00 0123456789abcdef 0 0
R ls 80000800 0000000000000000 00 0000000000000000 2 0
W ls 7ffffff8 deadbeefdeadbeef ff 0000000000000000 2 0
R ls 800007f8 0000000000000000 00 a5a5a5a5c3c3c3c3 0 0
R if 7ffffff8 0000000000000000 00 0000000000000000 2 0
R if 90000000 0000000000000000 00 0000000000000000 2 0
# paired reads on both ports
W ls 80000020 2020202020202020 ff 0000000000000000 0 0
W ls 80000028 2828282828282828 ff 0000000000000000 0 0
R if 80000020 0000000000000000 00 2020202020202020 0 1
R ls 80000028 0000000000000000 00 2828282828282828 0 0
R ls 80000020 0000000000000000 00 2020202020202020 0 1
R if 80000028 0000000000000000 00 2828282828282828 0 0
R if 80000010 0000000000000000 00 1122334405060708 0 1
R ls 80000800 0000000000000000 00 0000000000000000 2 0
# write alongside a fetch read
W ls 80000030 3030303030303030 ff 0000000000000000 0 1
R if 80000018 0000000000000000 00 00ff00ffff00ff00 0 0
W ls 80000030 cccccccccccccccc 3c 0000000000000000 0 0
R if 80000030 0000000000000000 00 3030cccccccc3030 0 1
R ls 80000000 0000000000000000 00 0123456789abcdef 0 0
R ls 800007f8 0000000000000000 00 a5a5a5a5c3c3c3c3 0 1
R if 80000028 0000000000000000 00 2828282828282828 0 0

// File: flist.f
common/mem_pkg.sv
sram/sram_array.sv
sram/axi_sram.sv
source/read_arbiter.sv
source/mem_subsys_top.sv
test/tb_mem_subsys.sv

// File: test/tb_mem_subsys.sv
`timescale 1ns/1ns
`default_nettype none

// testbench for the memory subsystem
// transactions come from test/mem_subsys_tests.txt one per line
module tb_mem_subsys;

	import mem_pkg::*;

	logic clk = 1'b0;
	logic rst;
	logic if_arvalid;
	addr_t if_araddr;
	logic ls_arvalid;
	addr_t ls_araddr;
	logic ls_awvalid;
	addr_t ls_awaddr;
	logic ls_wvalid;
	data_t ls_wdata;
	strb_t ls_wstrb;
	// response readies
	// bit 0 if_r  bit 1 ls_r  bit 2 ls_b
	logic [2:0] rdy_drv;

	logic if_arready;
	logic if_rvalid;
	data_t if_rdata;
	resp_t if_rresp;
	logic ls_arready;
	logic ls_rvalid;
	data_t ls_rdata;
	resp_t ls_rresp;
	logic ls_awready;
	logic ls_wready;
	logic ls_bvalid;
	resp_t ls_bresp;
	wire [2:0] vld_obs;

	// test table with one entry per file line
	bit t_write[$];
	bit t_ls[$];
	addr_t t_addr[$];
	data_t t_wdata[$];
	strb_t t_strb[$];
	data_t t_exp[$];
	resp_t t_resp[$];
	bit t_pair[$];

	string vname[3] = '{"if_r", "ls_r", "ls_b"};
	logic [31:0] lfsr = 32'h70c8_7813;
	// model of the arbiter's last grant
	// fetch wins the first tie
	bit last_grant_ls = 1'b1;
	bit grant_log[$];
	logic [2:0] active = 3'b000;
	bit loaded = 1'b0;
	int data_errors = 0;
	int resp_errors = 0;
	int flag_errors = 0;
	int other_errors = 0;

	assign vld_obs = {ls_bvalid, ls_rvalid, if_rvalid};

	always #5 clk = ~clk;

	mem_subsys_top #(
		.mem_base  (32'h8000_0000),
		.mem_words (256)
	) mem_subsys_top_i (
		.clk        (clk),
		.rst        (rst),
		.if_arvalid (if_arvalid),
		.if_araddr  (if_araddr),
		.if_arready (if_arready),
		.if_rvalid  (if_rvalid),
		.if_rdata   (if_rdata),
		.if_rresp   (if_rresp),
		.if_rready  (rdy_drv[0]),
		.ls_arvalid (ls_arvalid),
		.ls_araddr  (ls_araddr),
		.ls_arready (ls_arready),
		.ls_rvalid  (ls_rvalid),
		.ls_rdata   (ls_rdata),
		.ls_rresp   (ls_rresp),
		.ls_rready  (rdy_drv[1]),
		.ls_awvalid (ls_awvalid),
		.ls_awaddr  (ls_awaddr),
		.ls_awready (ls_awready),
		.ls_wvalid  (ls_wvalid),
		.ls_wdata   (ls_wdata),
		.ls_wstrb   (ls_wstrb),
		.ls_wready  (ls_wready),
		.ls_bvalid  (ls_bvalid),
		.ls_bresp   (ls_bresp),
		.ls_bready  (rdy_drv[2])
	);

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_bit(output bit b);
		lfsr = lfsr_next(lfsr);
		b = lfsr[0];
	endtask

	function automatic logic req_ready(input int k);
		return (k == 0) ? if_arready
			: ((k == 1) ? ls_arready : (ls_awready && ls_wready));
	endfunction

	function automatic data_t obs_data(input int k);
		return (k == 0) ? if_rdata : ((k == 1) ? ls_rdata : '0);
	endfunction

	function automatic resp_t obs_resp(input int k);
		return (k == 0) ? if_rresp : ((k == 1) ? ls_rresp : ls_bresp);
	endfunction

	task automatic check_data(input string name, input data_t exp, input data_t act);
		if (act !== exp) begin
			data_errors++;
			$display("FAILED %0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_resp(input string name, input resp_t exp, input resp_t act);
		if (act !== exp) begin
			resp_errors++;
			$display("FAILED %0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			flag_errors++;
			$display("FAILED %0t %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	// comment lines start with #
	task automatic load_tests();
		int fd;
		int cnt;
		int pr;
		string line;
		string op;
		string port;
		addr_t a;
		data_t wd;
		data_t ed;
		strb_t st;
		resp_t er;
		fd = $fopen("test/mem_subsys_tests.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("could not open test/mem_subsys_tests.txt");
		end else begin
			while ($fgets(line, fd)) begin
				cnt = 0;
				if (line.len() > 0 && line[0] != "#") begin
					cnt = $sscanf(line, "%s %s %h %h %h %h %h %d",
						op, port, a, wd, st, ed, er, pr);
				end
				if (cnt == 8) begin
					t_write.push_back(op == "W");
					t_ls.push_back(port == "ls");
					t_addr.push_back(a);
					t_wdata.push_back(wd);
					t_strb.push_back(st);
					t_exp.push_back(ed);
					t_resp.push_back(er);
					t_pair.push_back(pr != 0);
				end else if (cnt > 0) begin
					other_errors++;
					$display("malformed line in test file: %s", line);
				end
			end
			$fclose(fd);
			if (t_addr.size() == 0) begin
				other_errors++;
				$display("no transactions found in the test file");
			end
		end
	endtask

	// one transaction
	// starts and ends 1 ns after a rising edge
	task automatic run_txn(input int i);
		int k;
		bit rdy;
		bit stalled;
		bit done;
		data_t held_d;
		resp_t held_r;
		k = t_write[i] ? 2 : (t_ls[i] ? 1 : 0);
		stalled = 1'b0;
		done = 1'b0;
		if (k == 0) begin
			if_arvalid = 1'b1;
			if_araddr = t_addr[i];
		end else if (k == 1) begin
			ls_arvalid = 1'b1;
			ls_araddr = t_addr[i];
		end else begin
			ls_awvalid = 1'b1;
			ls_wvalid = 1'b1;
			ls_awaddr = t_addr[i];
			ls_wdata = t_wdata[i];
			ls_wstrb = t_strb[i];
		end
		// ready seen at negedge means the handshake is on the next edge
		do begin
			@(negedge clk);
		end while (!req_ready(k));
		@(posedge clk);
		#1;
		// request accepted, so a response is now expected on this port
		active[k] = 1'b1;
		if (k == 0) begin
			if_arvalid = 1'b0;
		end else if (k == 1) begin
			ls_arvalid = 1'b0;
		end else begin
			ls_awvalid = 1'b0;
			ls_wvalid = 1'b0;
		end
		if (k < 2) begin
			grant_log.push_back(k == 1);
			last_grant_ls = (k == 1);
		end
		// response phase with a random ready each cycle
		while (!done) begin
			random_bit(rdy);
			rdy_drv[k] = rdy;
			@(negedge clk);
			if (stalled) begin
				if (!vld_obs[k]) begin
					other_errors++;
					$display("%0t: %s response dropped while stalled",
						$time, vname[k]);
				end
				if (k < 2) begin
					check_data({vname[k], "data"}, held_d, obs_data(k));
				end
				check_resp({vname[k], "resp"}, held_r, obs_resp(k));
			end
			if (vld_obs[k] && rdy) begin
				if (k < 2) begin
					check_data({vname[k], "data"}, t_exp[i], obs_data(k));
				end
				check_resp({vname[k], "resp"}, t_resp[i], obs_resp(k));
				done = 1'b1;
			end
			stalled = vld_obs[k] && !rdy;
			held_d = obs_data(k);
			held_r = obs_resp(k);
			@(posedge clk);
			#1;
		end
		rdy_drv[k] = 1'b0;
		active[k] = 1'b0;
	endtask

	// a valid with nothing outstanding is a stray or repeated response
	always @(negedge clk) begin
		if (!rst) begin
			for (int k = 0; k < 3; k++) begin
				if (vld_obs[k] && !active[k]) begin
					other_errors++;
					$display("%0t: %s response with no request outstanding",
						$time, vname[k]);
				end
			end
		end
	end

	// watchdog budget grows with the table
	initial begin
		wait (loaded);
		repeat (t_addr.size() * 40 + 100) @(posedge clk);
		$display("run timed out waiting for a handshake");
		$display("TB FAILED");
		$finish;
	end

	initial begin
		int i;
		bit both_reads;
		bit first_ls;
		rst = 1'b1;
		if_arvalid = 1'b0;
		if_araddr = '0;
		ls_arvalid = 1'b0;
		ls_araddr = '0;
		ls_awvalid = 1'b0;
		ls_awaddr = '0;
		ls_wvalid = 1'b0;
		ls_wdata = '0;
		ls_wstrb = '0;
		rdy_drv = 3'b000;
		load_tests();
		loaded = 1'b1;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		// nothing pending out of reset
		@(negedge clk);
		check_flag("if_rvalid", 1'b0, if_rvalid);
		check_flag("ls_rvalid", 1'b0, ls_rvalid);
		check_flag("ls_bvalid", 1'b0, ls_bvalid);
		@(posedge clk);
		#1;
		i = 0;
		while (i < t_addr.size()) begin
			if (t_pair[i] && i + 1 < t_addr.size()) begin
				// tie goes to the port not granted last
				both_reads = !t_write[i] && !t_write[i + 1];
				first_ls = !last_grant_ls;
				grant_log.delete();
				fork
					run_txn(i);
					run_txn(i + 1);
				join
				if (both_reads) begin
					check_flag("first_grant_ls", first_ls, grant_log[0]);
				end
				i += 2;
			end else begin
				run_txn(i);
				i++;
			end
		end
		$display("errors: data %0d, resp %0d, flag %0d, other %0d",
			data_errors, resp_errors, flag_errors, other_errors);
		if (data_errors + resp_errors + flag_errors + other_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: source/mem_subsys_top.sv
`timescale 1ns/1ns
`default_nettype none

// memory side of the core
// fetch and load/store reads share the slave through the arbiter
// writes from load/store go straight to the slave
module mem_subsys_top #(
	parameter mem_pkg::addr_t mem_base  = 32'h8000_0000,
	parameter int             mem_words = 256
) (
	input  wire                 clk,
	input  wire                 rst,

	// fetch port, read only
	input  wire                 if_arvalid,
	input  wire mem_pkg::addr_t if_araddr,
	output logic                if_arready,
	output logic                if_rvalid,
	output mem_pkg::data_t      if_rdata,
	output mem_pkg::resp_t      if_rresp,
	input  wire                 if_rready,

	// load/store port, read side
	input  wire                 ls_arvalid,
	input  wire mem_pkg::addr_t ls_araddr,
	output logic                ls_arready,
	output logic                ls_rvalid,
	output mem_pkg::data_t      ls_rdata,
	output mem_pkg::resp_t      ls_rresp,
	input  wire                 ls_rready,

	// load/store port, write side
	input  wire                 ls_awvalid,
	input  wire mem_pkg::addr_t ls_awaddr,
	output logic                ls_awready,
	input  wire                 ls_wvalid,
	input  wire mem_pkg::data_t ls_wdata,
	input  wire mem_pkg::strb_t ls_wstrb,
	output logic                ls_wready,
	output logic                ls_bvalid,
	output mem_pkg::resp_t      ls_bresp,
	input  wire                 ls_bready
);

	import mem_pkg::*;

	// arbitrated read channel into the slave
	logic  s_arvalid;
	addr_t s_araddr;
	logic  s_arready;
	logic  s_rvalid;
	data_t s_rdata;
	resp_t s_rresp;
	logic  s_rready;

	read_arbiter read_arbiter_i (
		.clk        (clk),
		.rst        (rst),
		.if_arvalid (if_arvalid),
		.if_araddr  (if_araddr),
		.if_arready (if_arready),
		.if_rvalid  (if_rvalid),
		.if_rdata   (if_rdata),
		.if_rresp   (if_rresp),
		.if_rready  (if_rready),
		.ls_arvalid (ls_arvalid),
		.ls_araddr  (ls_araddr),
		.ls_arready (ls_arready),
		.ls_rvalid  (ls_rvalid),
		.ls_rdata   (ls_rdata),
		.ls_rresp   (ls_rresp),
		.ls_rready  (ls_rready),
		.s_arvalid  (s_arvalid),
		.s_araddr   (s_araddr),
		.s_arready  (s_arready),
		.s_rvalid   (s_rvalid),
		.s_rdata    (s_rdata),
		.s_rresp    (s_rresp),
		.s_rready   (s_rready)
	);

	// memory map is set here and passed down
	axi_sram #(
		.mem_base  (mem_base),
		.mem_words (mem_words)
	) axi_sram_i (
		.clk     (clk),
		.rst     (rst),
		.arvalid (s_arvalid),
		.araddr  (s_araddr),
		.arready (s_arready),
		.rvalid  (s_rvalid),
		.rdata   (s_rdata),
		.rresp   (s_rresp),
		.rready  (s_rready),
		.awvalid (ls_awvalid),
		.awaddr  (ls_awaddr),
		.awready (ls_awready),
		.wvalid  (ls_wvalid),
		.wdata   (ls_wdata),
		.wstrb   (ls_wstrb),
		.wready  (ls_wready),
		.bvalid  (ls_bvalid),
		.bresp   (ls_bresp),
		.bready  (ls_bready)
	);

endmodule

`default_nettype wire

// File: source/read_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

// joins the fetch and load/store read channels onto the slave
// round-robin on ties with one read in flight
module read_arbiter (
	input  wire                 clk,
	input  wire                 rst,

	// fetch read channel
	input  wire                 if_arvalid,
	input  wire mem_pkg::addr_t if_araddr,
	output logic                if_arready,
	output logic                if_rvalid,
	output mem_pkg::data_t      if_rdata,
	output mem_pkg::resp_t      if_rresp,
	input  wire                 if_rready,

	// load/store read channel
	input  wire                 ls_arvalid,
	input  wire mem_pkg::addr_t ls_araddr,
	output logic                ls_arready,
	output logic                ls_rvalid,
	output mem_pkg::data_t      ls_rdata,
	output mem_pkg::resp_t      ls_rresp,
	input  wire                 ls_rready,

	// toward the slave
	output logic                s_arvalid,
	output mem_pkg::addr_t      s_araddr,
	input  wire                 s_arready,
	input  wire                 s_rvalid,
	input  wire mem_pkg::data_t s_rdata,
	input  wire mem_pkg::resp_t s_rresp,
	output logic                s_rready
);

	// a read is in flight
	logic busy;
	// last granted port where 1 means load/store
	// doubles as the owner while busy
	logic owner_ls;
	// this cycle's pick
	logic grant_ls;
	logic s_ar_hs;
	logic s_r_hs;

	// tie goes to whoever was not granted last
	// a single requester just wins
	always_comb begin
		if (if_arvalid && ls_arvalid) begin
			grant_ls = !owner_ls;
		end else begin
			grant_ls = ls_arvalid;
		end
	end

	// forward path is purely combinational
	assign s_arvalid = !busy && (if_arvalid || ls_arvalid);
	assign s_araddr  = grant_ls ? ls_araddr : if_araddr;

	// both ports see arready low while busy
	assign if_arready = !busy && s_arready && !grant_ls;
	assign ls_arready = !busy && s_arready && grant_ls;

	assign s_ar_hs = s_arvalid && s_arready;
	assign s_r_hs  = s_rvalid && s_rready;

	// owner tracking
	// reset leaves load/store as last grant
	// so fetch wins the first tie
	always_ff @(posedge clk) begin
		if (rst) begin
			busy     <= 1'b0;
			owner_ls <= 1'b1;
		end else if (s_ar_hs) begin
			busy     <= 1'b1;
			owner_ls <= grant_ls;
		end else if (s_r_hs) begin
			busy <= 1'b0;
		end
	end

	// return path
	// only the owner sees valid and payload
	assign if_rvalid = s_rvalid && busy && !owner_ls;
	assign ls_rvalid = s_rvalid && busy && owner_ls;
	assign if_rdata  = owner_ls ? '0 : s_rdata;
	assign ls_rdata  = owner_ls ? s_rdata : '0;
	assign if_rresp  = owner_ls ? '0 : s_rresp;
	assign ls_rresp  = owner_ls ? s_rresp : '0;

	// owner's rready drives the slave
	assign s_rready = busy && (owner_ls ? ls_rready : if_rready);

	// slave takes no new address while an owner is recorded
	a_one_grant: assert property (@(posedge clk) disable iff (rst)
		busy |-> !s_arready)
		else $error("slave ready for a second read while one is in flight");

	// slave never answers without a recorded owner
	a_owned_resp: assert property (@(posedge clk) disable iff (rst)
		s_rvalid |-> busy)
		else $error("read response with no owner");

endmodule

`default_nettype wire

// File: sram/axi_sram.sv
`timescale 1ns/1ns
`default_nettype none

// valid/ready slave in front of the sram array
// read and write sides run independently, one transaction each
module axi_sram #(
	parameter mem_pkg::addr_t mem_base  = 32'h8000_0000,
	parameter int             mem_words = 256
) (
	input  wire                 clk,
	input  wire                 rst,

	// read address
	input  wire                 arvalid,
	input  wire mem_pkg::addr_t araddr,
	output logic                arready,

	// read data
	output logic                rvalid,
	output mem_pkg::data_t      rdata,
	output mem_pkg::resp_t      rresp,
	input  wire                 rready,

	// write address
	input  wire                 awvalid,
	input  wire mem_pkg::addr_t awaddr,
	output logic                awready,

	// write data
	input  wire                 wvalid,
	input  wire mem_pkg::data_t wdata,
	input  wire mem_pkg::strb_t wstrb,
	output logic                wready,

	// write response
	output logic                bvalid,
	output mem_pkg::resp_t      bresp,
	input  wire                 bready
);

	import mem_pkg::*;

	localparam int idx_w = $clog2(mem_words);

	// fsm states, same for both sides
	localparam logic st_idle = 1'b0;
	localparam logic st_resp = 1'b1;

	// window check
	// offset wraps when below mem_base, so one compare covers both ends
	function automatic logic in_window(input addr_t a);
		addr_t off;
		off = a - mem_base;
		return (off >> word_shift) < mem_words;
	endfunction

	// word index inside the window
	function automatic logic [idx_w-1:0] word_index(input addr_t a);
		addr_t off;
		off = a - mem_base;
		return off[word_shift +: idx_w];
	endfunction

	logic rd_state;
	logic wr_state;
	logic ar_hs;
	logic r_hs;
	logic aw_hs;
	logic b_hs;
	// set for an out-of-window read, picks zero data and slverr
	logic rd_err;
	data_t arr_rdata;

	// read side
	// ready only while idle, drops on the handshake
	assign arready = (rd_state == st_idle);
	assign ar_hs   = arvalid && arready;
	assign rvalid  = (rd_state == st_resp);
	assign r_hs    = rvalid && rready;

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_state <= st_idle;
		end else begin
			case (rd_state)
				st_idle: if (ar_hs) rd_state <= st_resp;
				st_resp: if (r_hs) rd_state <= st_idle;
				default: rd_state <= st_idle;
			endcase
		end
	end

	// error flag captured with the address
	always_ff @(posedge clk) begin
		if (ar_hs) begin
			rd_err <= !in_window(araddr);
		end
	end

	// response payload
	// array output is held until the next accepted read
	assign rdata = rd_err ? '0 : arr_rdata;
	assign rresp = rd_err ? resp_slverr : resp_okay;

	// write side
	// aw and w are taken together, and only when both are offered
	assign aw_hs   = awvalid && wvalid && (wr_state == st_idle);
	assign awready = aw_hs;
	assign wready  = aw_hs;
	assign bvalid  = (wr_state == st_resp);
	assign b_hs    = bvalid && bready;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_state <= st_idle;
		end else begin
			case (wr_state)
				st_idle: if (aw_hs) wr_state <= st_resp;
				st_resp: if (b_hs) wr_state <= st_idle;
				default: wr_state <= st_idle;
			endcase
		end
	end

	// b response decided at the handshake
	always_ff @(posedge clk) begin
		if (aw_hs) begin
			bresp <= in_window(awaddr) ? resp_okay : resp_slverr;
		end
	end

	// storage
	// out-of-window writes never reach the array
	sram_array #(
		.mem_words (mem_words)
	) sram_array_i (
		.clk   (clk),
		.we    (aw_hs && in_window(awaddr)),
		.widx  (word_index(awaddr)),
		.wdata (wdata),
		.wstrb (wstrb),
		.re    (ar_hs && in_window(araddr)),
		.ridx  (word_index(araddr)),
		.rdata (arr_rdata)
	);

	// stalled read response keeps valid and payload
	a_r_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else $error("read response changed while stalled");

	// stalled write response keeps valid and code
	a_b_hold: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else $error("write response changed while stalled");

endmodule

`default_nettype wire

// File: sram/sram_array.sv
`timescale 1ns/1ns
`default_nettype none

// plain word storage behind the bus slave
// one write port with byte strobes and one registered read port
module sram_array #(
	parameter int mem_words = 256
) (
	input  wire                           clk,
	input  wire                           we,
	input  wire [$clog2(mem_words)-1:0]   widx,
	input  wire mem_pkg::data_t           wdata,
	input  wire mem_pkg::strb_t           wstrb,
	input  wire                           re,
	input  wire [$clog2(mem_words)-1:0]   ridx,
	output mem_pkg::data_t                rdata
);

	import mem_pkg::*;

	// the storage itself
	data_t mem [mem_words];

	// byte-masked write
	// only lanes with their strobe set are touched
	always_ff @(posedge clk) begin
		if (we) begin
			for (int b = 0; b < bytes_per_word; b++) begin
				if (wstrb[b]) begin
					mem[widx][b*8 +: 8] <= wdata[b*8 +: 8];
				end
			end
		end
	end

	// registered read
	// word shows up one clock after re
	// value holds until the next re
	// lets the slave stall on rready
	// a write to the same word in the same cycle returns the old data
	always_ff @(posedge clk) begin
		if (re) begin
			rdata <= mem[ridx];
		end
	end

endmodule

`default_nettype wire

// File: common/mem_pkg.sv
`default_nettype none

// shared types for the memory subsystem
// both masters and the sram slave speak these widths
package mem_pkg;

	// byte address on the bus
	typedef logic [31:0] addr_t;

	// one data beat, a full 64-bit word
	typedef logic [63:0] data_t;

	// byte enables, bit i covers byte i of the beat
	typedef logic [7:0] strb_t;

	// response code on r and b channels
	typedef logic [1:0] resp_t;

	// normal completion
	localparam resp_t resp_okay = 2'b00;

	// slave error
	// used for any address outside the mapped window
	localparam resp_t resp_slverr = 2'b10;

	// bytes in one data beat
	localparam int bytes_per_word = 8;

	// low address bits dropped to get a word index
	localparam int word_shift = $clog2(bytes_per_word);

endpackage

`default_nettype wire
